//--- hw/iq_cfg_pkg.sv
/*
 * Issue queue configuration
 * Sizing constants shared by the issue stage RTL
 */

`default_nettype none

package iq_cfg_pkg;

    // --------------------------------------------------
    // Queue sizing
    // --------------------------------------------------

    // Number of issue queue entries, any value of 2 or more
    localparam int IQ_DEPTH = 4;

    // Index width for head and tail positions
    localparam int IQ_IDX_LEN = $clog2(IQ_DEPTH);

    // --------------------------------------------------
    // Datapath widths
    // --------------------------------------------------

    // RV32, width of pc and instruction word
    localparam int XLEN = 32;

endpackage : iq_cfg_pkg

`default_nettype wire

//--- hw/iq_instr_pkg.sv
/*
 * Issue queue instruction definitions
 * Queue entry layout, RISC-V major opcodes and execution unit selector
 */

`default_nettype none

package iq_instr_pkg;

    // --------------------------------------------------
    // Queue entry
    // --------------------------------------------------

    // One fetched instruction waiting for issue
    typedef struct packed {
        logic                         valid;
        // Fetch reported a fault for this pc
        logic                         except_raised;
        logic [iq_cfg_pkg::XLEN-1:0]  pc;
        logic [iq_cfg_pkg::XLEN-1:0]  instr;
    } iq_entry_t;

    // --------------------------------------------------
    // Major opcodes, instr[6:0]
    // --------------------------------------------------

    localparam int OPC_LEN = 7;

    localparam logic [OPC_LEN-1:0] OPC_OP     = 7'b0110011;
    localparam logic [OPC_LEN-1:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [OPC_LEN-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPC_LEN-1:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [OPC_LEN-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPC_LEN-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPC_LEN-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPC_LEN-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPC_LEN-1:0] OPC_STORE  = 7'b0100011;

    // --------------------------------------------------
    // Execution unit selector
    // --------------------------------------------------

    // Exception port catches faults and unknown opcodes
    typedef enum logic [1:0] {
        EU_ALU,
        EU_BRANCH,
        EU_LSU,
        EU_EXCEPT
    } exec_unit_e;

endpackage : iq_instr_pkg

`default_nettype wire

//--- hw/issue_queue_fifo.sv
/*
 * Circular issue queue
 * Entries carry a valid bit, head and tail indices live in external counters
 * Push from fetch, pop toward dispatch, single-cycle flush
 */

`default_nettype none

module issue_queue_fifo (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              flush_i,

    // Fetch side handshake
    input  logic                              fetch_valid_i,
    output logic                              fetch_ready_o,

    // Dispatch side handshake
    input  logic                              issue_ready_i,
    output logic                              issue_valid_o,

    // Entry in from fetch, head entry out to dispatch
    input  iq_instr_pkg::iq_entry_t           new_entry_i,
    output iq_instr_pkg::iq_entry_t           issued_entry_o,

    // Index counters
    input  logic [iq_cfg_pkg::IQ_IDX_LEN-1:0] head_idx_i,
    input  logic [iq_cfg_pkg::IQ_IDX_LEN-1:0] tail_idx_i,
    output logic                              head_cnt_en_o,
    output logic                              tail_cnt_en_o,
    output logic                              head_cnt_clr_o,
    output logic                              tail_cnt_clr_o
);

    import iq_cfg_pkg::*;
    import iq_instr_pkg::*;

    // Occupancy flag per slot
    logic [IQ_DEPTH-1:0] valid_q;
    // Slot payload, written on push only
    iq_entry_t           data_q [IQ_DEPTH];

    logic                fifo_full;
    logic                head_valid;
    logic                fifo_push;
    logic                fifo_pop;

    // --------------------------------------------------
    // Status
    // --------------------------------------------------

    // Full when every slot holds an entry
    assign fifo_full  = &valid_q;
    // Head slot occupied means something to issue
    assign head_valid = valid_q[head_idx_i];

    // --------------------------------------------------
    // Handshakes
    // --------------------------------------------------

    assign issue_valid_o = head_valid;
    assign fifo_pop      = head_valid & issue_ready_i;

    // Room available, or full with the head leaving this cycle
    // Flush drops any push in the same cycle
    assign fetch_ready_o = ~flush_i & (~fifo_full | fifo_pop);
    assign fifo_push     = fetch_valid_i & fetch_ready_o;

    // --------------------------------------------------
    // Index counter control
    // --------------------------------------------------

    // Each handshake advances its own index
    assign head_cnt_en_o  = fifo_pop;
    assign tail_cnt_en_o  = fifo_push;
    // Flush rewinds both indices to slot 0
    assign head_cnt_clr_o = flush_i;
    assign tail_cnt_clr_o = flush_i;

    // --------------------------------------------------
    // Valid bits
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            // Dropping every valid bit empties the queue
            valid_q <= '0;
        end else begin
            if (fifo_pop) begin
                valid_q[head_idx_i] <= 1'b0;
            end
            // Full push-with-pop hits the same slot, set must win
            if (fifo_push) begin
                valid_q[tail_idx_i] <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Payload storage
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (fifo_push) begin
            data_q[tail_idx_i] <= new_entry_i;
        end
    end

    // --------------------------------------------------
    // Head read port
    // --------------------------------------------------
    always_comb begin
        issued_entry_o       = data_q[head_idx_i];
        // Slot flag is the authority on validity
        issued_entry_o.valid = head_valid;
    end

endmodule : issue_queue_fifo

`default_nettype wire

//--- hw/issue_router.sv
/*
 * Dispatch router
 * Picks the execution unit for the head entry from its major opcode
 * and fetch fault flag, then steers the valid/ready pair to that unit
 */

`default_nettype none

module issue_router (
    // Head entry and its handshake from the queue
    input  iq_instr_pkg::iq_entry_t     issued_entry_i,
    input  logic                        issue_valid_i,
    output logic                        issue_ready_o,

    // Per-target valid outputs
    output logic                        alu_valid_o,
    output logic                        branch_valid_o,
    output logic                        lsu_valid_o,
    output logic                        except_valid_o,

    // Per-target ready inputs
    input  logic                        alu_ready_i,
    input  logic                        branch_ready_i,
    input  logic                        lsu_ready_i,
    input  logic                        except_ready_i,

    // Shared issue payload
    output logic [iq_cfg_pkg::XLEN-1:0] issue_pc_o,
    output logic [iq_cfg_pkg::XLEN-1:0] issue_instr_o
);

    import iq_instr_pkg::*;

    logic [OPC_LEN-1:0] opcode;
    exec_unit_e         unit_sel;

    // Major opcode field
    assign opcode = issued_entry_i.instr[OPC_LEN-1:0];

    // --------------------------------------------------
    // Target selection
    // --------------------------------------------------
    always_comb begin
        if (issued_entry_i.except_raised) begin
            // Fetch fault overrides the opcode
            unit_sel = EU_EXCEPT;
        end else begin
            case (opcode)
                OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: begin
                    unit_sel = EU_ALU;
                end
                // Jumps resolve in the branch unit too
                OPC_BRANCH, OPC_JAL, OPC_JALR: begin
                    unit_sel = EU_BRANCH;
                end
                OPC_LOAD, OPC_STORE: begin
                    unit_sel = EU_LSU;
                end
                // Unknown opcode, illegal instruction
                default: begin
                    unit_sel = EU_EXCEPT;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Handshake steering
    // --------------------------------------------------

    // Only the selected target sees valid
    assign alu_valid_o    = issue_valid_i & (unit_sel == EU_ALU);
    assign branch_valid_o = issue_valid_i & (unit_sel == EU_BRANCH);
    assign lsu_valid_o    = issue_valid_i & (unit_sel == EU_LSU);
    assign except_valid_o = issue_valid_i & (unit_sel == EU_EXCEPT);

    // Ready back from the selected target
    always_comb begin
        case (unit_sel)
            EU_ALU:    issue_ready_o = alu_ready_i;
            EU_BRANCH: issue_ready_o = branch_ready_i;
            EU_LSU:    issue_ready_o = lsu_ready_i;
            default:   issue_ready_o = except_ready_i;
        endcase
    end

    // Payload goes to all targets
    assign issue_pc_o    = issued_entry_i.pc;
    assign issue_instr_o = issued_entry_i.instr;

endmodule : issue_router

`default_nettype wire

//--- hw/issue_stage.sv
/*
 * Issue stage top
 * Issue queue with head and tail counters feeding the dispatch router
 */

`default_nettype none

module issue_stage (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,

    // Fetch side
    input  logic                        fetch_valid_i,
    output logic                        fetch_ready_o,
    input  iq_instr_pkg::iq_entry_t     new_entry_i,

    // Execution unit handshakes
    output logic                        alu_valid_o,
    input  logic                        alu_ready_i,
    output logic                        branch_valid_o,
    input  logic                        branch_ready_i,
    output logic                        lsu_valid_o,
    input  logic                        lsu_ready_i,
    output logic                        except_valid_o,
    input  logic                        except_ready_i,

    // Issued instruction
    output logic [iq_cfg_pkg::XLEN-1:0] issue_pc_o,
    output logic [iq_cfg_pkg::XLEN-1:0] issue_instr_o
);

    import iq_cfg_pkg::*;
    import iq_instr_pkg::*;

    // Queue indices and their control
    logic [IQ_IDX_LEN-1:0] head_idx;
    logic [IQ_IDX_LEN-1:0] tail_idx;
    logic                  head_cnt_en;
    logic                  tail_cnt_en;
    logic                  head_cnt_clr;
    logic                  tail_cnt_clr;

    // Queue to router
    logic                  issue_valid;
    logic                  issue_ready;
    iq_entry_t             issued_entry;

    // --------------------------------------------------
    // Head and tail counters
    // --------------------------------------------------
    modn_counter #(
        .MODULO  (IQ_DEPTH)
    ) i_head_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (head_cnt_en),
        .clr_i   (head_cnt_clr),
        .count_o (head_idx)
    );

    modn_counter #(
        .MODULO  (IQ_DEPTH)
    ) i_tail_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (tail_cnt_en),
        .clr_i   (tail_cnt_clr),
        .count_o (tail_idx)
    );

    // --------------------------------------------------
    // Issue queue
    // --------------------------------------------------
    issue_queue_fifo i_issue_queue_fifo (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_ready_o  (fetch_ready_o),
        .issue_ready_i  (issue_ready),
        .issue_valid_o  (issue_valid),
        .new_entry_i    (new_entry_i),
        .issued_entry_o (issued_entry),
        .head_idx_i     (head_idx),
        .tail_idx_i     (tail_idx),
        .head_cnt_en_o  (head_cnt_en),
        .tail_cnt_en_o  (tail_cnt_en),
        .head_cnt_clr_o (head_cnt_clr),
        .tail_cnt_clr_o (tail_cnt_clr)
    );

    // --------------------------------------------------
    // Dispatch router
    // --------------------------------------------------
    issue_router i_issue_router (
        .issued_entry_i (issued_entry),
        .issue_valid_i  (issue_valid),
        .issue_ready_o  (issue_ready),
        .alu_valid_o    (alu_valid_o),
        .branch_valid_o (branch_valid_o),
        .lsu_valid_o    (lsu_valid_o),
        .except_valid_o (except_valid_o),
        .alu_ready_i    (alu_ready_i),
        .branch_ready_i (branch_ready_i),
        .lsu_ready_i    (lsu_ready_i),
        .except_ready_i (except_ready_i),
        .issue_pc_o     (issue_pc_o),
        .issue_instr_o  (issue_instr_o)
    );

endmodule : issue_stage

`default_nettype wire

//--- hw/modn_counter.sv
/*
 * Modulo-N index counter
 * Steps on enable and wraps at MODULO, synchronous clear over enable
 */

`default_nettype none

module modn_counter #(
    // Wrap value, count runs 0 .. MODULO-1
    parameter int MODULO = iq_cfg_pkg::IQ_DEPTH
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              en_i,
    input  logic                              clr_i,
    output logic [iq_cfg_pkg::IQ_IDX_LEN-1:0] count_o
);

    // Last value before wrapping back to zero
    logic at_last;

    assign at_last = (int'(count_o) == MODULO - 1);

    // --------------------------------------------------
    // Index register
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_o <= '0;
        end else if (clr_i) begin
            // Clear wins over a concurrent step
            count_o <= '0;
        end else if (en_i) begin
            if (at_last) begin
                count_o <= '0;
            end else begin
                count_o <= count_o + 1'b1;
            end
        end
    end

endmodule : modn_counter

`default_nettype wire

//--- project.f
hw/iq_cfg_pkg.sv
hw/iq_instr_pkg.sv
hw/modn_counter.sv
hw/issue_queue_fifo.sv
hw/issue_router.sv
hw/issue_stage.sv
tests/tb_issue_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator
# Exit status follows the testbench verdict found in the log

set -e

cd "$(dirname "$0")"

LOG=run_sim.log

rm -rf obj_dir

verilator --binary --timing --assert \
    --top-module tb_issue_stage \
    -f project.f

./obj_dir/Vtb_issue_stage > "$LOG" 2>&1

cat "$LOG"

if grep -qx "STATUS: PASS" "$LOG"; then
    exit 0
fi

echo "Simulation did not pass, see $LOG"
exit 1

//--- tests/tb_issue_stage.sv
/*
 * Issue stage testbench
 * Reference queue model, LCG stimulus and concurrent checks on the DUT
 */

`default_nettype none

module tb_issue_stage;

    import iq_cfg_pkg::*;
    import iq_instr_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int RAND_CYCLES  = 400;
    // Two resets, random phase, directed fill, flush and drain phases
    localparam int STIM_CYCLES  = 2 * RESET_CYCLES + RAND_CYCLES + 4 * IQ_DEPTH + 40;
    localparam int TIMEOUT      = STIM_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD;

    logic            clk_i;
    logic            rst_n_i;
    logic            flush_i;
    logic            fetch_valid_i;
    logic            fetch_ready_o;
    iq_entry_t       new_entry_i;
    logic            alu_valid_o;
    logic            alu_ready_i;
    logic            branch_valid_o;
    logic            branch_ready_i;
    logic            lsu_valid_o;
    logic            lsu_ready_i;
    logic            except_valid_o;
    logic            except_ready_i;
    logic [XLEN-1:0] issue_pc_o;
    logic [XLEN-1:0] issue_instr_o;

    // Reference model, oldest entry at index 0
    iq_entry_t       model_q [$];
    int              exp_count;
    logic [XLEN-1:0] exp_pc;
    logic [XLEN-1:0] exp_instr;
    exec_unit_e      exp_unit;
    // Expected {alu, branch, lsu, except} valids
    logic [3:0]      exp_vec;
    logic            sel_ready;
    logic            exp_fetch_ready;

    // Head snapshot for the stall check
    logic            hold_q;
    logic [3:0]      hold_vec;
    logic [XLEN-1:0] hold_pc;

    logic [3:0]      valid_vec;
    logic            issue_fire;
    logic            fetch_fire;
    int              push_total  = 0;
    int              pop_total   = 0;
    int              error_count = 0;
    logic [31:0]     lcg_state;

    issue_stage i_issue_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_ready_o  (fetch_ready_o),
        .new_entry_i    (new_entry_i),
        .alu_valid_o    (alu_valid_o),
        .alu_ready_i    (alu_ready_i),
        .branch_valid_o (branch_valid_o),
        .branch_ready_i (branch_ready_i),
        .lsu_valid_o    (lsu_valid_o),
        .lsu_ready_i    (lsu_ready_i),
        .except_valid_o (except_valid_o),
        .except_ready_i (except_ready_i),
        .issue_pc_o     (issue_pc_o),
        .issue_instr_o  (issue_instr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------

    // Numerical Recipes LCG constants
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic iq_entry_t random_entry();
        iq_entry_t   e;
        logic [31:0] r;
        logic [6:0]  opc;
        r = next_rand();
        case (r[31:28])
            4'd0:    opc = OPC_OP;
            4'd1:    opc = OPC_OP_IMM;
            4'd2:    opc = OPC_LUI;
            4'd3:    opc = OPC_AUIPC;
            4'd4:    opc = OPC_BRANCH;
            4'd5:    opc = OPC_JAL;
            4'd6:    opc = OPC_JALR;
            4'd7:    opc = OPC_LOAD;
            4'd8:    opc = OPC_STORE;
            // MISC-MEM and SYSTEM are not routed to a unit
            4'd9:    opc = 7'b0001111;
            4'd10:   opc = 7'b1110011;
            4'd11:   opc = OPC_OP;
            4'd12:   opc = OPC_LOAD;
            4'd13:   opc = OPC_BRANCH;
            4'd14:   opc = OPC_STORE;
            default: opc = 7'b1111111;
        endcase
        e.valid         = 1'b1;
        e.except_raised = (r[27:25] == 3'd0);
        r               = next_rand();
        e.pc            = {r[31:2], 2'b00};
        r               = next_rand();
        e.instr         = {r[31:7], opc};
        return e;
    endfunction

    task automatic set_readies(input logic level);
        alu_ready_i    = level;
        branch_ready_i = level;
        lsu_ready_i    = level;
        except_ready_i = level;
    endtask

    // --------------------------------------------------
    // Reference rules
    // --------------------------------------------------

    // Fault flag first, then the major opcode
    function automatic exec_unit_e expected_unit(input iq_entry_t e);
        exec_unit_e u;
        if (e.except_raised) begin
            u = EU_EXCEPT;
        end else begin
            case (e.instr[6:0])
                OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: u = EU_ALU;
                OPC_BRANCH, OPC_JAL, OPC_JALR:          u = EU_BRANCH;
                OPC_LOAD, OPC_STORE:                    u = EU_LSU;
                default:                                u = EU_EXCEPT;
            endcase
        end
        return u;
    endfunction

    function automatic logic [3:0] unit_onehot(input exec_unit_e u);
        case (u)
            EU_ALU:    return 4'b1000;
            EU_BRANCH: return 4'b0100;
            EU_LSU:    return 4'b0010;
            default:   return 4'b0001;
        endcase
    endfunction

    assign valid_vec  = {alu_valid_o, branch_valid_o, lsu_valid_o, except_valid_o};
    assign issue_fire = |(valid_vec & {alu_ready_i, branch_ready_i, lsu_ready_i,
                                       except_ready_i});
    assign fetch_fire = fetch_valid_i & fetch_ready_o;

    always_comb begin
        case (exp_unit)
            EU_ALU:    sel_ready = alu_ready_i;
            EU_BRANCH: sel_ready = branch_ready_i;
            EU_LSU:    sel_ready = lsu_ready_i;
            default:   sel_ready = except_ready_i;
        endcase
        // Room left, or full with the head leaving on this edge
        exp_fetch_ready = !flush_i &&
            ((exp_count < IQ_DEPTH) || ((exp_count != 0) && sel_ready));
    end

    // Model follows the handshakes seen on each rising edge
    always @(posedge clk_i or negedge rst_n_i) begin
        iq_entry_t head;
        if (!rst_n_i) begin
            model_q.delete();
            exp_count <= 0;
            exp_pc    <= '0;
            exp_instr <= '0;
            exp_unit  <= EU_ALU;
            exp_vec   <= '0;
            hold_q    <= 1'b0;
            hold_vec  <= '0;
            hold_pc   <= '0;
        end else begin
            hold_q   <= (exp_count != 0) && !sel_ready && !flush_i;
            hold_vec <= valid_vec;
            hold_pc  <= issue_pc_o;
            if (flush_i) begin
                model_q.delete();
            end else begin
                if (issue_fire && (model_q.size() != 0)) begin
                    void'(model_q.pop_front());
                    pop_total++;
                end
                if (fetch_fire) begin
                    model_q.push_back(new_entry_i);
                    push_total++;
                end
            end
            exp_count <= model_q.size();
            if (model_q.size() != 0) begin
                head = model_q[0];
                exp_pc    <= head.pc;
                exp_instr <= head.instr;
                exp_unit  <= expected_unit(head);
                exp_vec   <= unit_onehot(expected_unit(head));
            end else begin
                exp_vec <= '0;
            end
        end
    end

    // --------------------------------------------------
    // Concurrent checks
    // --------------------------------------------------
    a_payload: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (exp_count != 0) |-> (issue_pc_o == exp_pc && issue_instr_o == exp_instr))
    else begin
        error_count++;
        $display("ERR %0t: issued pc %h instr %h, expected pc %h instr %h",
                 $time, issue_pc_o, issue_instr_o, exp_pc, exp_instr);
    end

    // One-hot to the right unit, all low when empty
    a_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_vec == exp_vec)
    else begin
        error_count++;
        $display("ERR %0t: unit valids %b, expected %b", $time, valid_vec, exp_vec);
    end

    a_fetch_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_ready_o == exp_fetch_ready)
    else begin
        error_count++;
        $display("ERR %0t: fetch_ready_o %b with %0d queued, expected %b",
                 $time, fetch_ready_o, exp_count, exp_fetch_ready);
    end

    a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hold_q |-> (valid_vec == hold_vec && issue_pc_o == hold_pc))
    else begin
        error_count++;
        $display("ERR %0t: stalled head changed, valids %b pc %h, held %b pc %h",
                 $time, valid_vec, issue_pc_o, hold_vec, hold_pc);
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        int          start_push;
        int          start_pop;
        logic [31:0] r;
        lcg_state     = 32'd13;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        fetch_valid_i = 1'b0;
        new_entry_i   = '0;
        set_readies(1'b0);
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        // Fill with every unit stalled
        start_push = push_total;
        for (int i = 0; i < IQ_DEPTH + 3; i++) begin
            fetch_valid_i = 1'b1;
            new_entry_i   = random_entry();
            @(negedge clk_i);
        end
        assert (push_total - start_push == IQ_DEPTH)
        else begin
            error_count++;
            $display("ERR %0t: %0d pushes accepted while stalled, expected %0d",
                     $time, push_total - start_push, IQ_DEPTH);
        end

        // Full queue, push and pop on one edge
        start_push = push_total;
        start_pop  = pop_total;
        set_readies(1'b1);
        new_entry_i = random_entry();
        @(negedge clk_i);
        assert (push_total == start_push + 1 && pop_total == start_pop + 1)
        else begin
            error_count++;
            $display("ERR %0t: full queue took %0d pushes and %0d pops, expected 1 and 1",
                     $time, push_total - start_push, pop_total - start_pop);
        end

        // Flush with a push pending, the push is dropped
        set_readies(1'b0);
        flush_i     = 1'b1;
        new_entry_i = random_entry();
        start_push  = push_total;
        @(negedge clk_i);
        flush_i       = 1'b0;
        fetch_valid_i = 1'b0;
        assert (push_total == start_push)
        else begin
            error_count++;
            $display("ERR %0t: push accepted in the flush cycle", $time);
        end
        @(negedge clk_i);

        for (int i = 0; i < RAND_CYCLES; i++) begin
            r              = next_rand();
            fetch_valid_i  = (r[31:30] != 2'b00);
            alu_ready_i    = r[29];
            branch_ready_i = r[28];
            lsu_ready_i    = r[27];
            except_ready_i = r[26];
            flush_i        = (r[25:20] == 6'd0);
            new_entry_i    = random_entry();
            @(negedge clk_i);
        end

        // Drain what is left
        flush_i       = 1'b0;
        fetch_valid_i = 1'b0;
        set_readies(1'b1);
        while (exp_count != 0) @(negedge clk_i);

        // Reset with entries queued
        set_readies(1'b0);
        fetch_valid_i = 1'b1;
        repeat (3) begin
            new_entry_i = random_entry();
            @(negedge clk_i);
        end
        fetch_valid_i = 1'b0;
        rst_n_i       = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;
        repeat (3) @(negedge clk_i);
        assert (valid_vec == 4'b0000 && fetch_ready_o)
        else begin
            error_count++;
            $display("ERR %0t: after reset unit valids %b fetch_ready_o %b, expected 0000 and 1",
                     $time, valid_vec, fetch_ready_o);
        end

        $display("Run complete: %0d errors, %0d pushes, %0d issues",
                 error_count, push_total, pop_total);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the stimulus length
    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule : tb_issue_stage

`default_nettype wire
